// ==== Makefile ====
# Verilator build and run for the chip-RAM controller testbench

VERILATOR ?= verilator
TOP       ?= tbChipRam
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= All checks passed

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Passes only when the pass message shows up in the output
run: $(SIM)
	./$(SIM) $(RUN_ARGS) | tee /dev/stderr | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/chipRamPkg.sv ====
// SDR SDRAM stands in for Amiga chip RAM. Bank 0 only and one column per access.
// Mode register fixes burst length 1 and CAS latency 2. Timing constants must agree with it.
`default_nettype none

package chipRamPkg;

    ////////////////////
    // Widths
    ////////////////////

    typedef logic [31:0] ramData_t;     // One SDRAM word
    typedef logic [15:0] dmaData_t;     // One Agnus DMA word
    typedef logic [3:0]  byteMask_t;    // 1 writes the byte
    typedef logic [10:0] sdramAddr_t;   // SDRAM A10..A0
    typedef logic [9:0]  rowAddr_t;
    typedef logic [8:0]  colAddr_t;
    typedef logic [9:0]  dmaMux_t;      // Agnus DRA9..DRA0, row then column

    // SDRAM commands as issued by the sequencer
    typedef enum logic [2:0] {
        cmdNop,
        cmdPrecharge,
        cmdModeRegister,
        cmdAutoRefresh,
        cmdActivate,
        cmdRead,
        cmdWrite
    } ramCmd_e;

    // One access as handed to the sequencer
    typedef struct packed {
        rowAddr_t  row;
        colAddr_t  col;
        logic      write;
        ramData_t  wdata;
        byteMask_t mask;    // Zero on reads
    } ramReq_t;

    // Everything the controller drives toward the SDRAM
    typedef struct packed {
        logic       nCs;
        logic       nRas;
        logic       nCas;
        logic       nWe;
        logic       cke;
        sdramAddr_t addr;
        logic [3:0] dqm;    // 1 masks a byte
        ramData_t   dqOut;
        logic       dqOe;   // Write data on the bus
    } sdramPins_t;

    ////////////////////
    // SDRAM timing
    ////////////////////

    // Write burst, op mode 00, CL 2, sequential, BL 1
    localparam sdramAddr_t modeRegValue = 11'b0_0_00_010_0_000;

    localparam int unsigned casLatency = 2;    // Read command to sampled data
    localparam int unsigned rcdCycles  = 2;    // Activate to read or write

endpackage

`default_nettype wire

// ==== rtl/chipRamTop.sv ====
// Single clock design. All ports, the Agnus strobes included, are synchronous to CAS_AGNUS.
// Bank address is fixed at 0 and read and write data use separate vectors.
`default_nettype none

module chipRamTop import chipRamPkg::*; #(
    parameter int unsigned chipRamMb       = 1,    // 1 or 2 MB map
    parameter int unsigned refreshInterval = 54    // Cycles per auto-refresh
) (
    input  logic        CAS_AGNUS,
    input  logic        nRESET,
    // AXI4-Lite CPU port
    input  logic [20:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  ramData_t    wdata,
    input  byteMask_t   wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic [20:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic        rvalid,
    input  logic        rready,
    output ramData_t    rdata,
    output logic [1:0]  rresp,
    // Agnus DMA port
    input  logic        nRas0,
    input  logic        nRas1,
    input  logic        nCasL,
    input  logic        nCasU,
    input  logic        nAwe,
    input  dmaMux_t     dra,
    input  dmaData_t    dmaWdata,
    output dmaData_t    dmaRdata,
    output logic        dmaRvalid,
    // SDRAM
    output sdramPins_t  sdram,
    input  ramData_t    dqIn
);

    ramReq_t  cpuReq;
    logic     cpuReqValid;
    logic     cpuDone;
    ramData_t rdData;
    ramReq_t  dmaReq;
    logic     dmaReqValid;
    logic     dmaDone;
    logic     dmaHalf;
    logic     refreshDue;
    logic     refreshAck;

    cpuRamPort #(.chipRamMb(chipRamMb)) cpuPort (.*);

    dmaAddrCapture #(.chipRamMb(chipRamMb)) dmaCapture (.*);

    refreshTimer #(.refreshInterval(refreshInterval)) refresh (.*);

    sdramSequencer sequencer (.*);

endmodule

`default_nettype wire

// ==== rtl/cpuRamPort.sv ====
// AXI4-Lite slave for single 32-bit transfers. One transaction in flight at a time.
// Responses are always OKAY and a stalled B or R channel holds off the next request.
`default_nettype none

module cpuRamPort import chipRamPkg::*; #(
    parameter int unsigned chipRamMb = 1    // 1 or 2 MB chip RAM map
) (
    input  logic        CAS_AGNUS,
    input  logic        nRESET,
    input  logic [20:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  ramData_t    wdata,
    input  byteMask_t   wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic [20:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic        rvalid,
    input  logic        rready,
    output ramData_t    rdata,
    output logic [1:0]  rresp,
    output ramReq_t     cpuReq,
    output logic        cpuReqValid,
    input  logic        cpuDone,
    input  ramData_t    rdData
);

    typedef enum logic [1:0] {cpuIdle, cpuBusy, cpuRespond} cpuState_e;

    cpuState_e   state;
    logic        isWrite;   // Kind of the held transaction
    logic        wrAccept;
    logic        rdAccept;
    logic [20:0] addr;

    // AW and W are taken together, a write wins over a read in the same cycle
    assign wrAccept = (state == cpuIdle) && awvalid && wvalid;
    assign rdAccept = (state == cpuIdle) && arvalid && !wrAccept;
    assign awready  = wrAccept;
    assign wready   = wrAccept;
    assign arready  = rdAccept;
    assign addr     = wrAccept ? awaddr : araddr;

    assign cpuReqValid = (state == cpuBusy);
    assign bvalid      = (state == cpuRespond) && isWrite;     // Held until bready
    assign rvalid      = (state == cpuRespond) && !isWrite;    // Held until rready
    assign bresp       = 2'b00;
    assign rresp       = 2'b00;

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            state   <= cpuIdle;
            isWrite <= 1'b0;
        end else begin
            case (state)
                cpuIdle: begin
                    if (wrAccept || rdAccept) begin
                        state   <= cpuBusy;
                        isWrite <= wrAccept;
                    end
                end
                cpuBusy: begin
                    if (cpuDone) state <= cpuRespond;   // Sequencer finished the column
                end
                cpuRespond: begin
                    if ((bvalid && bready) || (rvalid && rready)) state <= cpuIdle;
                end
                default: state <= cpuIdle;
            endcase
        end
    end

    // Agnus style map. Row is A19 A17..A9, column is A20 A18 A8..A2
    always_ff @(posedge CAS_AGNUS) begin
        if (wrAccept || rdAccept) begin
            cpuReq.row   <= {addr[19], addr[17:9]};
            cpuReq.col   <= {((chipRamMb == 2) ? addr[20] : 1'b0), addr[18], addr[8:2]};
            cpuReq.write <= wrAccept;
            cpuReq.wdata <= wdata;
            cpuReq.mask  <= wrAccept ? wstrb : '0;
        end
        if (cpuDone && !isWrite) rdata <= rdData;  // Full word back to the master
    end

endmodule

`default_nettype wire

// ==== rtl/dmaAddrCapture.sv ====
// Agnus strobes are taken as synchronous to CAS_AGNUS and pass a two-stage sampler.
// DRA, nAwe and write data travel through the same stages so they stay aligned.
`default_nettype none

module dmaAddrCapture import chipRamPkg::*; #(
    parameter int unsigned chipRamMb = 1    // 1 MB takes row bit 9 from the RAS line used
) (
    input  logic     CAS_AGNUS,
    input  logic     nRESET,
    input  logic     nRas0,
    input  logic     nRas1,
    input  logic     nCasL,
    input  logic     nCasU,
    input  logic     nAwe,
    input  dmaMux_t  dra,
    input  dmaData_t dmaWdata,
    output ramReq_t  dmaReq,
    output logic     dmaReqValid,
    input  logic     dmaDone,
    output logic     dmaHalf        // 1 for the upper 16 bits
);

    // Everything Agnus presents in one cycle
    typedef struct packed {
        logic     nRas0;
        logic     nRas1;
        logic     nCasL;
        logic     nCasU;
        logic     nAwe;
        dmaMux_t  dra;
        dmaData_t wdata;
    } agnusBus_t;

    agnusBus_t stage1;
    agnusBus_t stage2;
    logic      rasSeen;     // Previous sampled RAS state
    logic      casSeen;
    logic      oneRas;
    logic      anyCas;
    logic      rowEdge;
    logic      colEdge;

    assign oneRas  = stage2.nRas0 ^ stage2.nRas1;      // Exactly one bank strobe low
    assign anyCas  = !(stage2.nCasL && stage2.nCasU);
    assign rowEdge = oneRas && !rasSeen;
    assign colEdge = anyCas && !casSeen;

    ////////////////////
    // Sampler
    ////////////////////

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            stage1      <= '1;  // Strobes idle high
            stage2      <= '1;
            rasSeen     <= 1'b0;
            casSeen     <= 1'b0;
            dmaReqValid <= 1'b0;
        end else begin
            stage1  <= '{nRas0, nRas1, nCasL, nCasU, nAwe, dra, dmaWdata};
            stage2  <= stage1;
            rasSeen <= oneRas;
            casSeen <= anyCas;
            if (colEdge) begin
                dmaReqValid <= 1'b1;    // One request per CAS
            end else if (dmaDone) begin
                dmaReqValid <= 1'b0;
            end
        end
    end

    ////////////////////
    // Address latches
    ////////////////////

    always_ff @(posedge CAS_AGNUS) begin
        if (rowEdge) begin
            dmaReq.row <= {((chipRamMb == 2) ? stage2.dra[9] : !stage2.nRas1), stage2.dra[8:0]};
        end
        if (colEdge) begin
            dmaReq.col   <= stage2.dra[9:1];   // DRA0 is the word half
            dmaReq.write <= !stage2.nAwe;
            dmaReq.wdata <= stage2.dra[0] ? {stage2.wdata, 16'h0000} : {16'h0000, stage2.wdata};
            dmaReq.mask  <= stage2.dra[0] ? 4'b1100 : 4'b0011;
            dmaHalf      <= stage2.dra[0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/refreshTimer.sv ====
// refreshInterval must exceed the preload so the count can reach it.
`default_nettype none

module refreshTimer #(
    parameter int unsigned refreshInterval = 54    // Cycles between auto-refresh commands
) (
    input  logic CAS_AGNUS,
    input  logic nRESET,
    input  logic refreshAck,
    output logic refreshDue
);

    // Preload on ack so an access in flight plus the idle slot fit in the interval
    localparam int unsigned leadCycles = 4;
    localparam int unsigned cntW       = $clog2(refreshInterval + 1);

    logic [cntW-1:0] count;

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            count      <= '0;
            refreshDue <= 1'b0;
        end else if (refreshAck) begin
            count      <= cntW'(leadCycles);   // Refresh just went out
            refreshDue <= 1'b0;
        end else if (count == cntW'(refreshInterval)) begin
            refreshDue <= 1'b1;                 // Saturated, hold until acked
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sdramSequencer.sv ====
// Commands are registered and decoded onto the pins. Each access is a fixed 8-cycle slot.
// Refresh beats DMA, DMA beats CPU, and a slot always closes its row with a precharge.
`default_nettype none

module sdramSequencer import chipRamPkg::*; (
    input  logic       CAS_AGNUS,
    input  logic       nRESET,
    input  ramReq_t    cpuReq,
    input  logic       cpuReqValid,
    output logic       cpuDone,
    input  ramReq_t    dmaReq,
    input  logic       dmaReqValid,
    output logic       dmaDone,
    input  logic       dmaHalf,
    input  logic       refreshDue,
    output logic       refreshAck,
    output ramData_t   rdData,
    output dmaData_t   dmaRdata,
    output logic       dmaRvalid,
    output sdramPins_t sdram,
    input  ramData_t   dqIn
);

    typedef enum logic [1:0] {seqInit, seqIdle, seqRefresh, seqAccess} seqState_e;

    // Steps count the cycle whose command is on the pins, so each load happens one step early
    localparam logic [3:0] rwStep      = 4'(rcdCycles - 1);
    localparam logic [3:0] dataStep    = 4'(rcdCycles + casLatency);   // Sample dq, precharge
    localparam logic [3:0] accessLast  = 4'd7;
    localparam logic [3:0] refreshLast = 4'd6;    // Auto-refresh then 6 NOPs
    localparam logic [3:0] initLast    = 4'd13;

    seqState_e  state;
    logic [3:0] step;
    ramCmd_e    cmd;        // Command on the pins this cycle
    logic       cke;
    logic       dqOe;
    ramReq_t    cur;        // Access in progress
    logic       curDma;
    logic       grantRefresh;
    logic       grantDma;
    logic       grantCpu;
    logic [3:0] cmdLines;   // nCs nRas nCas nWe
    sdramAddr_t addrBus;

    ////////////////////
    // Arbitration
    ////////////////////

    assign grantRefresh = (state == seqIdle) && refreshDue;
    assign grantDma     = (state == seqIdle) && !refreshDue && dmaReqValid;
    assign grantCpu     = (state == seqIdle) && !refreshDue && !dmaReqValid && cpuReqValid;

    ////////////////////
    // Pin decode
    ////////////////////

    always_comb begin
        cmdLines = 4'b1111;     // Deselect
        addrBus  = '0;
        case (cmd)
            cmdPrecharge: begin
                cmdLines = 4'b0010;
                addrBus  = 11'h400;     // A10 closes every bank
            end
            cmdModeRegister: begin
                cmdLines = 4'b0000;
                addrBus  = modeRegValue;
            end
            cmdAutoRefresh: cmdLines = 4'b0001;
            cmdActivate: begin
                cmdLines = 4'b0011;
                addrBus  = {1'b0, cur.row};
            end
            cmdRead: begin
                cmdLines = 4'b0101;
                addrBus  = {2'b00, cur.col};    // A10 low, no auto precharge
            end
            cmdWrite: begin
                cmdLines = 4'b0100;
                addrBus  = {2'b00, cur.col};
            end
            default: cmdLines = 4'b1111;
        endcase
    end

    assign sdram = '{nCs: cmdLines[3], nRas: cmdLines[2], nCas: cmdLines[1], nWe: cmdLines[0],
                     cke: cke, addr: addrBus,
                     dqm: (cmd == cmdWrite) ? ~cur.mask : 4'b0000,
                     dqOut: cur.wdata, dqOe: dqOe};

    ////////////////////
    // Command FSM
    ////////////////////

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            state      <= seqInit;
            step       <= '0;
            cmd        <= cmdNop;
            cke        <= 1'b0;
            dqOe       <= 1'b0;
            curDma     <= 1'b0;
            cpuDone    <= 1'b0;
            dmaDone    <= 1'b0;
            dmaRvalid  <= 1'b0;
            refreshAck <= 1'b0;
        end else begin
            cmd        <= cmdNop;     // Every command lasts one cycle
            dqOe       <= 1'b0;
            cpuDone    <= 1'b0;
            dmaDone    <= 1'b0;
            dmaRvalid  <= 1'b0;
            refreshAck <= 1'b0;
            step       <= step + 4'd1;
            case (state)
                seqInit: begin
                    case (step)
                        4'd0:       cke <= 1'b1;
                        4'd1:       cmd <= cmdPrecharge;
                        4'd2:       cmd <= cmdModeRegister;
                        4'd4, 4'd9: cmd <= cmdAutoRefresh;
                        initLast:   state <= seqIdle;
                        default:    cmd <= cmdNop;
                    endcase
                end
                seqIdle: begin
                    step <= '0;
                    if (grantRefresh) begin
                        cmd        <= cmdAutoRefresh;
                        refreshAck <= 1'b1;
                        state      <= seqRefresh;
                    end else if (grantDma || grantCpu) begin
                        cmd    <= cmdActivate;
                        curDma <= grantDma;
                        state  <= seqAccess;
                    end
                end
                seqRefresh: begin
                    if (step == refreshLast) state <= seqIdle;
                end
                seqAccess: begin
                    if (step == rwStep) begin
                        cmd  <= cur.write ? cmdWrite : cmdRead;
                        dqOe <= cur.write;
                    end
                    if (step == dataStep) begin
                        cmd       <= cmdPrecharge;
                        cpuDone   <= !curDma;
                        dmaDone   <= curDma;
                        dmaRvalid <= curDma && !cur.write;
                    end
                    if (step == accessLast) state <= seqIdle;
                end
                default: state <= seqIdle;
            endcase
        end
    end

    // Request and read data registers
    always_ff @(posedge CAS_AGNUS) begin
        if (grantDma || grantCpu) cur <= grantDma ? dmaReq : cpuReq;
        if ((state == seqAccess) && (step == dataStep)) begin
            rdData   <= dqIn;
            dmaRdata <= dmaHalf ? dqIn[31:16] : dqIn[15:0];   // Half picked by DRA0
        end
    end

endmodule

`default_nettype wire

// ==== verif/chipRam_assert.sv ====
// Watches the SDRAM pins of the sequencer. Bank 0 only and no bursts.
// The refresh bound assumes the default interval that the testbench also uses.
`default_nettype none

module sdramProtocolChecks import chipRamPkg::*; #(
    parameter int unsigned refreshInterval = 54
) (
    input logic       CAS_AGNUS,
    input logic       nRESET,
    input sdramPins_t sdram
);

    int unsigned errCount = 0;     // Read by the testbench monitor
    logic        isAct;
    logic        isRd;
    logic        isWr;
    logic        isPre;
    logic        isRef;
    logic        isMrs;
    logic        rowClosed;         // Precharge seen since the last activate
    logic        mrsSeen;
    logic [1:0]  initRefreshes;     // Saturates at 2
    logic [7:0]  sinceRefresh;

    // Pin decode, nCs nRas nCas nWe
    assign isAct = !sdram.nCs && !sdram.nRas && sdram.nCas && sdram.nWe;
    assign isRd  = !sdram.nCs && sdram.nRas && !sdram.nCas && sdram.nWe;
    assign isWr  = !sdram.nCs && sdram.nRas && !sdram.nCas && !sdram.nWe;
    assign isPre = !sdram.nCs && !sdram.nRas && sdram.nCas && !sdram.nWe;
    assign isRef = !sdram.nCs && !sdram.nRas && !sdram.nCas && sdram.nWe;
    assign isMrs = !sdram.nCs && !sdram.nRas && !sdram.nCas && !sdram.nWe;

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            rowClosed     <= 1'b0;
            mrsSeen       <= 1'b0;
            initRefreshes <= 2'd0;
            sinceRefresh  <= 8'd0;
        end else begin
            if (isPre) rowClosed <= 1'b1;
            if (isAct) rowClosed <= 1'b0;
            if (isMrs) mrsSeen <= 1'b1;
            if (isRef && mrsSeen && (initRefreshes != 2'd2)) initRefreshes <= initRefreshes + 2'd1;
            if (isRef) sinceRefresh <= 8'd0;
            else if (sinceRefresh != 8'hff) sinceRefresh <= sinceRefresh + 8'd1;
        end
    end

    ////////////////////
    // Properties
    ////////////////////

    ckeBeforeCommands: assert property (@(posedge CAS_AGNUS) disable iff (!nRESET)
        !sdram.nCs |-> sdram.cke)
        else begin errCount++; $error("command issued with cke low"); end

    modeRegisterLoad: assert property (@(posedge CAS_AGNUS) disable iff (!nRESET)
        isMrs |-> (sdram.addr == modeRegValue) && rowClosed)
        else begin errCount++; $error("mode register load wrong value or not after precharge"); end

    activateAfterInit: assert property (@(posedge CAS_AGNUS) disable iff (!nRESET)
        isAct |-> (initRefreshes == 2'd2) && rowClosed)
        else begin errCount++; $error("activate before init or without precharge"); end

    columnSpacing: assert property (@(posedge CAS_AGNUS) disable iff (!nRESET)
        (isRd || isWr) |-> $past(isAct, rcdCycles))
        else begin errCount++; $error("read or write not rcdCycles after activate"); end

    refreshSpacing: assert property (@(posedge CAS_AGNUS) disable iff (!nRESET)
        (initRefreshes == 2'd2) |-> (32'(sinceRefresh) <= refreshInterval + 8))
        else begin errCount++; $error("auto-refresh interval exceeded"); end

endmodule

bind sdramSequencer sdramProtocolChecks protocolChecks (
    .CAS_AGNUS(CAS_AGNUS),
    .nRESET(nRESET),
    .sdram(sdram)
);

`default_nettype wire

// ==== verif/tbChipRam.sv ====
// Runs the 1 MB map with the default refresh interval. Reference memory follows the map rules.
// SDRAM model covers bank 0 and answers reads casLatency cycles after the command.
`default_nettype none

module tbChipRam import chipRamPkg::*; ();

    localparam int unsigned pairCount      = 24;
    localparam int unsigned watchdogCycles = pairCount * 2 * 90 + 1500;

    logic CAS_AGNUS;
    logic nRESET;
    logic [20:0] awaddr;
    logic awvalid;
    logic awready;
    ramData_t wdata;
    byteMask_t wstrb;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic [1:0] bresp;
    logic [20:0] araddr;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;
    ramData_t rdata;
    logic [1:0] rresp;
    logic nRas0;
    logic nRas1;
    logic nCasL;
    logic nCasU;
    logic nAwe;
    dmaMux_t dra;
    dmaData_t dmaWdata;
    dmaData_t dmaRdata;
    logic dmaRvalid;
    sdramPins_t sdram;
    ramData_t dqIn;

    ramData_t    memModel [logic [18:0]];  // SDRAM contents, {row, col}
    ramData_t    memRef   [logic [18:0]];  // Expected contents
    ramData_t    readPipe [casLatency];
    rowAddr_t    openRow;
    logic [20:0] addrPool [8];             // Small pool so writes overlap

    chipRamTop uut (.*);

    assign dqIn = readPipe[casLatency-1];

    initial CAS_AGNUS = 1'b0;
    always #4 CAS_AGNUS = !CAS_AGNUS;

    function automatic ramData_t fillWord(input logic [18:0] key);
        return {key[12:0], key};    // Unwritten words depend on the full address
    endfunction

    function automatic logic [18:0] keyOf(input logic [20:0] a);
        return {a[19], a[17:9], 1'b0, a[18], a[8:2]};  // Row then column, 1 MB map
    endfunction

    function automatic logic [20:0] cpuAddr(input logic ras1, input logic [8:0] rowLow,
                                            input colAddr_t col);
        return {col[8], ras1, col[7], rowLow, col[6:0], 2'b00};
    endfunction

    function automatic ramData_t refRead(input logic [18:0] key);
        return memRef.exists(key) ? memRef[key] : fillWord(key);
    endfunction

    function automatic ramData_t modelRead(input logic [18:0] key);
        return memModel.exists(key) ? memModel[key] : fillWord(key);
    endfunction

    function automatic logic activateOnPins();
        return !sdram.nCs && !sdram.nRas && sdram.nCas && sdram.nWe;
    endfunction

    task automatic failRun(input string why);
        $display("Checks failed");
        $fatal(1, "%s", why);
    endtask

    task automatic checkWord(input string what, input ramData_t got, input ramData_t exp);
        assert (got === exp) else begin
            $display("error %0t: %s returned %h, expected %h", $time, what, got, exp);
            failRun("data mismatch");
        end
    endtask

    ////////////////////
    // SDRAM model
    ////////////////////

    always @(posedge CAS_AGNUS) begin : sdramModel
        logic [18:0] key;
        ramData_t    word;
        key  = {openRow, sdram.addr[8:0]};
        word = modelRead(key);
        for (int i = int'(casLatency) - 1; i > 0; i--) readPipe[i] <= readPipe[i-1];
        if (!sdram.nCs) begin
            case ({sdram.nRas, sdram.nCas, sdram.nWe})
                3'b011: openRow <= sdram.addr[9:0];  // Activate
                3'b101: readPipe[0] <= word;
                3'b100: begin
                    assert (sdram.dqOe) else begin
                        $display("error %0t: write command without dqOe", $time);
                        failRun("write data not driven");
                    end
                    for (int b = 0; b < 4; b++) begin
                        if (!sdram.dqm[b]) word[8*b +: 8] = sdram.dqOut[8*b +: 8];
                    end
                    memModel[key] = word;
                end
                default: ;
            endcase
        end
    end

    ////////////////////
    // Bus drivers
    ////////////////////

    task automatic axiWrite(input logic [20:0] addr, input ramData_t data, input byteMask_t strb);
        logic       pending;
        logic       accepted;
        logic [1:0] resp;
        ramData_t   word;
        @(negedge CAS_AGNUS);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(posedge CAS_AGNUS);
        while (!(awready && wready)) @(posedge CAS_AGNUS);    // Handshake seen at the edge
        @(negedge CAS_AGNUS);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        word = refRead(keyOf(addr));
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) word[8*b +: 8] = data[8*b +: 8];   // Byte merge
        end
        memRef[keyOf(addr)] = word;
        pending = 1'b0;
        do begin
            bready = 1'($urandom);
            assert (!(pending && !bvalid)) else begin
                $display("error %0t: bvalid dropped before bready", $time);
                failRun("write response lost");
            end
            accepted = bvalid && bready;
            pending  = bvalid && !bready;
            resp     = bresp;
            @(negedge CAS_AGNUS);
        end while (!accepted);
        bready = 1'b0;
        checkWord("write response", {30'h0, resp}, 32'h0);    // Always OKAY
    endtask

    task automatic axiReadCheck(input logic [20:0] addr);
        logic       pending;
        logic       accepted;
        logic [1:0] resp;
        ramData_t   exp;
        ramData_t   got;
        exp = refRead(keyOf(addr));
        @(negedge CAS_AGNUS);
        araddr  = addr;
        arvalid = 1'b1;
        @(posedge CAS_AGNUS);
        while (!arready) @(posedge CAS_AGNUS);
        @(negedge CAS_AGNUS);
        arvalid = 1'b0;
        pending = 1'b0;
        do begin
            rready = 1'($urandom);
            assert (!(pending && !rvalid)) else begin
                $display("error %0t: rvalid dropped before rready", $time);
                failRun("read response lost");
            end
            accepted = rvalid && rready;
            pending  = rvalid && !rready;
            got      = rdata;
            resp     = rresp;
            @(negedge CAS_AGNUS);
        end while (!accepted);
        rready = 1'b0;
        checkWord("read response", {30'h0, resp}, 32'h0);
        checkWord("CPU read", got, exp);
    endtask

    // One Agnus cycle. RAS line picks row bit 9, DRA0 picks the half
    task automatic dmaCycle(input logic ras1, input logic [8:0] rowLow, input colAddr_t col,
                            input logic half, input logic write, input dmaData_t data);
        logic [18:0] key;
        ramData_t    word;
        key = {ras1, rowLow, col};
        @(negedge CAS_AGNUS);
        dra   = {1'($urandom), rowLow};    // DRA9 ignored in 1 MB mode
        nRas0 = ras1;
        nRas1 = !ras1;
        repeat (2) @(negedge CAS_AGNUS);
        dra      = {col, half};
        nAwe     = !write;
        dmaWdata = data;
        nCasL    = half;
        nCasU    = !half;
        word     = refRead(key);
        if (write) begin
            while (!uut.dmaReqValid) @(negedge CAS_AGNUS);
            while (uut.dmaReqValid) @(negedge CAS_AGNUS);
            word[16*half +: 16] = data;
            memRef[key] = word;
        end else begin
            while (!dmaRvalid) @(negedge CAS_AGNUS);
            checkWord("DMA read", {16'h0000, dmaRdata}, {16'h0000, word[16*half +: 16]});
        end
        nCasL = 1'b1;
        nCasU = 1'b1;
        nRas0 = 1'b1;
        nRas1 = 1'b1;
        nAwe  = 1'b1;
        @(negedge CAS_AGNUS);
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin : watchdog
        repeat (watchdogCycles) @(posedge CAS_AGNUS);
        failRun("watchdog timeout, the run did not finish");
    end

    always @(negedge CAS_AGNUS) begin
        if (uut.sequencer.protocolChecks.errCount != 0) failRun("SDRAM protocol assertion failed");
    end

    initial begin : stimulus
        logic [8:0] rowC;
        void'($urandom(60));
        nRESET = 1'b0;
        {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
        {araddr, arvalid, rready, dra, dmaWdata} = '0;
        {nRas0, nRas1, nCasL, nCasU, nAwe} = 5'b11111;
        for (int i = 0; i < int'(casLatency); i++) readPipe[i] <= '0;
        openRow <= '0;
        for (int i = 0; i < 8; i++) addrPool[i] = {1'b0, 18'($urandom), 2'b00};
        repeat (10) @(negedge CAS_AGNUS);
        nRESET = 1'b1;

        // CPU traffic with random strobes and ready stalls
        for (int i = 0; i < int'(pairCount); i++) begin
            axiWrite(addrPool[3'($urandom)], $urandom, 4'($urandom));
            axiReadCheck(addrPool[3'($urandom)]);
        end

        repeat (240) @(negedge CAS_AGNUS);      // Idle, refresh only

        // DMA through both RAS lines, then seen from the CPU side
        dmaCycle(1'b0, 9'h0a5, 9'h03c, 1'b0, 1'b1, 16'h1234);
        axiReadCheck(cpuAddr(1'b0, 9'h0a5, 9'h03c));
        dmaCycle(1'b1, 9'h15a, 9'h0c3, 1'b1, 1'b1, 16'hbeef);
        axiReadCheck(cpuAddr(1'b1, 9'h15a, 9'h0c3));
        axiWrite(cpuAddr(1'b1, 9'h033, 9'h07e), $urandom, 4'hf);
        dmaCycle(1'b1, 9'h033, 9'h07e, 1'b0, 1'b0, 16'h0000);
        dmaCycle(1'b1, 9'h033, 9'h07e, 1'b1, 1'b0, 16'h0000);

        // Both requests valid in the same cycle, DMA must activate first
        rowC = addrPool[0][17:9] ^ 9'h001;      // Row bits A17..A9, other row than the CPU read
        fork
            dmaCycle(1'b0, rowC, 9'h011, 1'b1, 1'b1, 16'h5a5a);
            begin
                repeat (4) @(negedge CAS_AGNUS);
                axiReadCheck(addrPool[0]);
            end
            begin
                @(negedge CAS_AGNUS);
                while (!activateOnPins()) @(negedge CAS_AGNUS);
                checkWord("first activate row", {22'h0, sdram.addr[9:0]}, {22'h0, 1'b0, rowC});
            end
        join
        axiReadCheck(cpuAddr(1'b0, rowC, 9'h011));

        if (uut.sequencer.protocolChecks.errCount != 0) begin
            failRun("SDRAM protocol assertion failed");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/chipRamPkg.sv
rtl/cpuRamPort.sv
rtl/dmaAddrCapture.sv
rtl/refreshTimer.sv
rtl/sdramSequencer.sv
rtl/chipRamTop.sv
verif/chipRam_assert.sv
verif/tbChipRam.sv
